//--- logic/mc_pkg.sv
/*
 * Shared widths, vector typedefs, DRAM command codes and
 * mode-register defaults of the memory controller
 */
`default_nettype none

package mc_pkg;

   // ****************************************
   // Address and data widths
   // ****************************************
   localparam int DRAM_BANKS = 8;
   localparam int BANK_W     = 3;
   localparam int ROW_W      = 14;
   localparam int COL_W      = 10;
   localparam int ADDR_W     = BANK_W + ROW_W + COL_W;   // Flat front-end address
   localparam int ID_W       = 8;
   localparam int BL         = 8;                        // Beats per burst
   localparam int DQ_W       = 8;
   localparam int DATA_W     = DQ_W * BL;                // One full burst
   localparam int DRAM_ADDR_W = 16;                      // Row, column or MRS value

   typedef logic [BANK_W-1:0]      bank_t;
   typedef logic [ROW_W-1:0]       row_t;
   typedef logic [COL_W-1:0]       col_t;
   typedef logic [ADDR_W-1:0]      addr_t;
   typedef logic [ID_W-1:0]        id_t;
   typedef logic [DATA_W-1:0]      data_t;
   typedef logic [DRAM_ADDR_W-1:0] dram_addr_t;

   // ****************************************
   // DRAM commands
   // ****************************************
   typedef logic [2:0] dram_cmd_t;

   localparam dram_cmd_t CMD_NOP = 3'd0;
   localparam dram_cmd_t CMD_ACT = 3'd1;
   localparam dram_cmd_t CMD_RD  = 3'd2;
   localparam dram_cmd_t CMD_WR  = 3'd3;
   localparam dram_cmd_t CMD_PRE = 3'd4;
   localparam dram_cmd_t CMD_REF = 3'd5;
   localparam dram_cmd_t CMD_MRS = 3'd6;

   // MR0..MR3, written in this order at power-up
   localparam dram_addr_t MRS_INIT [4] = '{16'h0520, 16'h0040, 16'h0000, 16'h0000};

endpackage

`default_nettype wire

//--- logic/request_queue.sv
/*
 * Circular request FIFO between front end and scheduler, with stall
 */
`timescale 1ns/1ps
`default_nettype none

module request_queue #(
   parameter int DEPTH = 4
) (
   input  logic          clk,
   input  logic          rst_n_i,
   input  logic          req_i,
   input  logic          write_i,
   input  mc_pkg::addr_t addr_i,
   input  mc_pkg::id_t   id_i,
   input  mc_pkg::data_t wdata_i,
   input  logic          init_done_i,
   input  logic          pop_i,
   output logic          stall_o,
   output logic          head_valid_o,
   output logic          head_write_o,
   output mc_pkg::addr_t head_addr_o,
   output mc_pkg::id_t   head_id_o,
   output mc_pkg::data_t head_wdata_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic          write_mem [DEPTH];
   mc_pkg::addr_t addr_mem  [DEPTH];
   mc_pkg::id_t   id_mem    [DEPTH];
   mc_pkg::data_t wdata_mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;

   assign stall_o      = (count_q == CNT_W'(DEPTH)) || !init_done_i;
   assign push         = req_i && !stall_o;
   assign head_valid_o = (count_q != '0);

   assign head_write_o = write_mem[rd_ptr_q];
   assign head_addr_o  = addr_mem[rd_ptr_q];
   assign head_id_o    = id_mem[rd_ptr_q];
   assign head_wdata_o = wdata_mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (push) begin
         write_mem[wr_ptr_q] <= write_i;
         addr_mem[wr_ptr_q]  <= addr_i;
         id_mem[wr_ptr_q]    <= id_i;
         wdata_mem[wr_ptr_q] <= wdata_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop_i) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
         if (push && !pop_i) count_q <= count_q + 1'b1;
         else if (pop_i && !push) count_q <= count_q - 1'b1;
      end
   end

   // Scheduler only retires an entry it has seen at the head
   a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n_i)
      pop_i |-> head_valid_o)
      else $error("request_queue: pop while empty");

endmodule

`default_nettype wire

//--- logic/refresh_timer.sv
/*
 * Periodic refresh interval counter, four-phase request to scheduler
 */
`timescale 1ns/1ps
`default_nettype none

module refresh_timer #(
   parameter int AREFI_CYCLES = 2880
) (
   input  logic clk,
   input  logic rst_n_i,
   input  logic init_done_i,
   input  logic ref_ack_i,
   output logic ref_req_o
);

   localparam int CNT_W = $clog2(AREFI_CYCLES);

   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q     <= '0;
         ref_req_o <= 1'b0;
      end else if (init_done_i) begin
         if (ref_ack_i) ref_req_o <= 1'b0;        // Phase 2 seen, release request
         if (cnt_q == CNT_W'(AREFI_CYCLES-1)) begin
            // Hold at terminal count until the previous handshake is closed
            if (!ref_req_o && !ref_ack_i) begin
               ref_req_o <= 1'b1;
               cnt_q     <= '0;
            end
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   a_ack_after_req : assert property (@(posedge clk) disable iff (!rst_n_i)
      $rose(ref_ack_i) |-> ref_req_o)
      else $error("refresh_timer: ack without request");

endmodule

`default_nettype wire

//--- logic/init_sequencer.sv
/*
 * Power-up sequence: DRAM reset low and high phases, then MR0..MR3
 */
`timescale 1ns/1ps
`default_nettype none

module init_sequencer #(
   parameter int RESET_LOW_CYCLES  = 50000,
   parameter int RESET_HIGH_CYCLES = 65000
) (
   input  logic               clk,
   input  logic               rst_n_i,
   output logic               reset_m_n_o,
   output logic               init_cmd_valid_o,
   output mc_pkg::dram_addr_t init_addr_o,
   output logic               init_done_o
);

   localparam int LONGEST = (RESET_LOW_CYCLES > RESET_HIGH_CYCLES) ?
                            RESET_LOW_CYCLES : RESET_HIGH_CYCLES;
   localparam int CNT_W   = ($clog2(LONGEST) < 2) ? 2 : $clog2(LONGEST);

   typedef enum logic [1:0] {RST_LOW, RST_HIGH, MRS, DONE} init_state_t;

   init_state_t      state_q;
   logic [CNT_W-1:0] cnt_q;      // Phase timer, also MR index

   assign reset_m_n_o      = (state_q != RST_LOW);
   assign init_cmd_valid_o = (state_q == MRS);
   assign init_addr_o      = mc_pkg::MRS_INIT[cnt_q[1:0]];
   assign init_done_o      = (state_q == DONE);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= RST_LOW;
         cnt_q   <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
         case (state_q)
            RST_LOW: if (cnt_q == CNT_W'(RESET_LOW_CYCLES-1)) begin
               state_q <= RST_HIGH;
               cnt_q   <= '0;
            end
            RST_HIGH: if (cnt_q == CNT_W'(RESET_HIGH_CYCLES-1)) begin
               state_q <= MRS;
               cnt_q   <= '0;
            end
            MRS: if (cnt_q == CNT_W'(3)) state_q <= DONE;   // Last MR written
            default: cnt_q <= cnt_q;                        // DONE, idle forever
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/cmd_scheduler.sv
/*
 * In-order DRAM command scheduler with open-row tracking per bank,
 * tRCD/tRP/tRAS/tRFC timers, refresh and init command issue
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_scheduler #(
   parameter int T_RCD = 6,
   parameter int T_RP  = 6,
   parameter int T_RAS = 15,
   parameter int T_RFC = 44
) (
   input  logic               clk,
   input  logic               rst_n_i,
   input  logic               head_valid_i,
   input  logic               head_write_i,
   input  mc_pkg::addr_t      head_addr_i,
   input  mc_pkg::id_t        head_id_i,
   input  mc_pkg::data_t      head_wdata_i,
   input  logic               init_cmd_valid_i,
   input  mc_pkg::dram_addr_t init_addr_i,
   input  logic               init_done_i,
   input  logic               ref_req_i,
   output logic               pop_o,
   output logic               ref_ack_o,
   output logic               cmd_valid_o,
   output mc_pkg::dram_cmd_t  cmd_o,
   output mc_pkg::bank_t      bank_o,
   output mc_pkg::dram_addr_t addr_o,
   output mc_pkg::id_t        id_o,
   output mc_pkg::data_t      w_data_o
);

   localparam int NB      = mc_pkg::DRAM_BANKS;
   localparam int LONG1   = (T_RCD > T_RP) ? T_RCD : T_RP;
   localparam int LONGEST = (LONG1 > T_RFC) ? LONG1 : T_RFC;
   localparam int WAIT_W  = $clog2(LONGEST + 1);
   localparam int RAS_W   = $clog2(T_RAS + 1);

   typedef enum logic [2:0] {IDLE, PRE_ALL, REF_WAIT, ACT, CAS, PRE_ONE} sched_state_t;

   // ****************************************
   // Address split, bank bits on top
   // ****************************************
   mc_pkg::bank_t req_bank;
   mc_pkg::row_t  req_row;
   mc_pkg::col_t  req_col;

   assign req_bank = head_addr_i[mc_pkg::ADDR_W-1 -: mc_pkg::BANK_W];
   assign req_row  = head_addr_i[mc_pkg::COL_W +: mc_pkg::ROW_W];
   assign req_col  = head_addr_i[mc_pkg::COL_W-1:0];

   sched_state_t       state_q, state_d;
   logic [WAIT_W-1:0]  wait_q, wait_d;       // Global command gap
   logic [NB-1:0]      open_q;
   mc_pkg::row_t       open_row_q [NB];
   logic [RAS_W-1:0]   ras_cnt_q  [NB];
   logic               ref_ack_d;
   logic               any_open;
   mc_pkg::bank_t      pre_bank;             // Lowest open bank for refresh

   logic               issue;
   mc_pkg::dram_cmd_t  issue_cmd;
   mc_pkg::bank_t      issue_bank;
   mc_pkg::dram_addr_t issue_addr;

   assign any_open = |open_q;

   always_comb begin
      pre_bank = '0;
      for (int b = NB-1; b >= 0; b--) begin
         if (open_q[b]) pre_bank = mc_pkg::bank_t'(b);
      end
   end

   // ****************************************
   // Next state and command select
   // ****************************************
   always_comb begin
      state_d    = state_q;
      wait_d     = (wait_q != '0) ? wait_q - 1'b1 : '0;
      ref_ack_d  = ref_ack_o;
      pop_o      = 1'b0;
      issue      = 1'b0;
      issue_cmd  = mc_pkg::CMD_NOP;
      issue_bank = req_bank;
      issue_addr = mc_pkg::dram_addr_t'(req_col);
      if (wait_q == '0) begin
         case (state_q)
            IDLE: begin
               if (init_cmd_valid_i) begin
                  issue      = 1'b1;
                  issue_cmd  = mc_pkg::CMD_MRS;
                  issue_bank = '0;
                  issue_addr = init_addr_i;
               end else if (init_done_i && ref_req_i) begin
                  state_d = PRE_ALL;                 // Refresh wins between requests
               end else if (init_done_i && head_valid_i) begin
                  if (!open_q[req_bank]) state_d = ACT;
                  else if (open_row_q[req_bank] == req_row) state_d = CAS;   // Row hit
                  else state_d = PRE_ONE;
               end
            end
            PRE_ALL: begin
               if (!any_open) begin
                  issue     = 1'b1;
                  issue_cmd = mc_pkg::CMD_REF;
                  ref_ack_d = 1'b1;
                  wait_d    = WAIT_W'(T_RFC-1);
                  state_d   = REF_WAIT;
               end else if (ras_cnt_q[pre_bank] == '0) begin
                  issue      = 1'b1;
                  issue_cmd  = mc_pkg::CMD_PRE;
                  issue_bank = pre_bank;
                  wait_d     = WAIT_W'(T_RP-1);
               end
            end
            REF_WAIT: if (!ref_req_i) begin          // Close the handshake
               ref_ack_d = 1'b0;
               state_d   = IDLE;
            end
            PRE_ONE: if (ras_cnt_q[req_bank] == '0) begin
               issue     = 1'b1;
               issue_cmd = mc_pkg::CMD_PRE;
               wait_d    = WAIT_W'(T_RP-1);
               state_d   = ACT;
            end
            ACT: begin
               issue      = 1'b1;
               issue_cmd  = mc_pkg::CMD_ACT;
               issue_addr = mc_pkg::dram_addr_t'(req_row);
               wait_d     = WAIT_W'(T_RCD-1);
               state_d    = CAS;
            end
            CAS: begin
               issue     = 1'b1;
               issue_cmd = head_write_i ? mc_pkg::CMD_WR : mc_pkg::CMD_RD;
               pop_o     = 1'b1;
               state_d   = IDLE;
            end
            default: state_d = IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= IDLE;
         wait_q      <= '0;
         ref_ack_o   <= 1'b0;
         open_q      <= '0;
         cmd_valid_o <= 1'b0;
         cmd_o       <= mc_pkg::CMD_NOP;
      end else begin
         state_q     <= state_d;
         wait_q      <= wait_d;
         ref_ack_o   <= ref_ack_d;
         cmd_valid_o <= issue;
         cmd_o       <= issue_cmd;
         if (issue && issue_cmd == mc_pkg::CMD_ACT) open_q[issue_bank] <= 1'b1;
         if (issue && issue_cmd == mc_pkg::CMD_PRE) open_q[issue_bank] <= 1'b0;
      end
   end

   // Minimum ACT to PRE time per bank
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ras_cnt_q <= '{default: '0};
      end else begin
         for (int b = 0; b < NB; b++) begin
            if (issue && issue_cmd == mc_pkg::CMD_ACT && issue_bank == mc_pkg::bank_t'(b))
               ras_cnt_q[b] <= RAS_W'(T_RAS-1);
            else if (ras_cnt_q[b] != '0)
               ras_cnt_q[b] <= ras_cnt_q[b] - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         bank_o   <= issue_bank;
         addr_o   <= issue_addr;
         id_o     <= head_id_i;
         w_data_o <= head_wdata_i;   // PHY takes write data with WR
      end
      if (issue && issue_cmd == mc_pkg::CMD_ACT) open_row_q[issue_bank] <= req_row;
   end

   a_cas_open_bank : assert property (@(posedge clk) disable iff (!rst_n_i)
      cmd_valid_o && (cmd_o == mc_pkg::CMD_RD || cmd_o == mc_pkg::CMD_WR) |-> open_q[bank_o])
      else $error("cmd_scheduler: CAS to a closed bank");

endmodule

`default_nettype wire

//--- logic/read_return.sv
/*
 * Two-entry buffer for PHY read data toward the front end
 */
`timescale 1ns/1ps
`default_nettype none

module read_return (
   input  logic          clk,
   input  logic          rst_n_i,
   input  mc_pkg::data_t r_data_i,
   input  mc_pkg::id_t   r_id_i,
   input  logic          r_valid_i,
   input  logic          fe_grant_i,
   output logic          r_grant_o,
   output mc_pkg::data_t fe_rdata_o,
   output mc_pkg::id_t   fe_rid_o,
   output logic          fe_rvalid_o
);

   mc_pkg::data_t data_mem [2];
   mc_pkg::id_t   id_mem   [2];
   logic          wr_ptr_q, rd_ptr_q;
   logic [1:0]    count_q, count_d;
   logic          push, pop;

   assign push        = r_valid_i && r_grant_o;
   assign pop         = fe_rvalid_o && fe_grant_i;
   assign fe_rvalid_o = (count_q != 2'd0);
   assign fe_rdata_o  = data_mem[rd_ptr_q];
   assign fe_rid_o    = id_mem[rd_ptr_q];
   assign count_d     = count_q + {1'b0, push} - {1'b0, pop};

   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr_q] <= r_data_i;
         id_mem[wr_ptr_q]   <= r_id_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q  <= 1'b0;
         rd_ptr_q  <= 1'b0;
         count_q   <= 2'd0;
         r_grant_o <= 1'b0;             // Opens one cycle out of reset
      end else begin
         if (push) wr_ptr_q <= ~wr_ptr_q;
         if (pop) rd_ptr_q <= ~rd_ptr_q;
         count_q   <= count_d;
         r_grant_o <= (count_d != 2'd2);   // Free entry next cycle
      end
   end

   // ****************************************
   // Front-end valid/grant rule
   // ****************************************
   a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
      fe_rvalid_o && !fe_grant_i |=> fe_rvalid_o && $stable(fe_rdata_o) && $stable(fe_rid_o))
      else $error("read_return: output changed under back-pressure");

endmodule

`default_nettype wire

//--- logic/mem_ctrl_top.sv
/*
 * Memory controller request path top level, joining the request
 * queue, init and refresh logic, scheduler and read-return buffer
 */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top #(
   parameter int QUEUE_DEPTH       = 4,
   parameter int AREFI_CYCLES      = 2880,
   parameter int T_RCD             = 6,
   parameter int T_RP              = 6,
   parameter int T_RAS             = 15,
   parameter int T_RFC             = 44,
   parameter int RESET_LOW_CYCLES  = 50000,
   parameter int RESET_HIGH_CYCLES = 65000
) (
   input  logic                   clk,
   input  logic                   rst_n_i,
   // Front-end request port
   input  logic                   fe_req_i,
   input  logic                   fe_write_i,
   input  mc_pkg::addr_t          fe_addr_i,
   input  mc_pkg::id_t            fe_id_i,
   input  mc_pkg::data_t          fe_wdata_i,
   output logic                   fe_stall_o,
   // Front-end read port
   output mc_pkg::data_t          fe_rdata_o,
   output mc_pkg::id_t            fe_rid_o,
   output logic                   fe_rvalid_o,
   input  logic                   fe_rgrant_i,
   // PHY command port
   output logic                   ctrl_valid_o,
   output mc_pkg::dram_cmd_t      ctrl_cmd_o,
   output mc_pkg::bank_t          ctrl_bank_o,
   output mc_pkg::dram_addr_t     ctrl_addr_o,
   output mc_pkg::id_t            ctrl_id_o,
   output mc_pkg::data_t          ctrl_w_data_o,
   // PHY read data
   input  mc_pkg::data_t          ctrl_r_data_i,
   input  mc_pkg::id_t            ctrl_r_id_i,
   input  logic                   ctrl_r_valid_i,
   output logic                   ctrl_r_grant_o,
   output logic                   reset_m_n_o      // DRAM RESET#
);

   // ****************************************
   // Internal links
   // ****************************************
   logic               head_valid;
   logic               head_write;
   mc_pkg::addr_t      head_addr;
   mc_pkg::id_t        head_id;
   mc_pkg::data_t      head_wdata;
   logic               pop;
   logic               ref_req;
   logic               ref_ack;
   logic               init_cmd_valid;
   mc_pkg::dram_addr_t init_addr;
   logic               init_done;

   request_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
      .clk(clk), .rst_n_i(rst_n_i),
      .req_i(fe_req_i), .write_i(fe_write_i), .addr_i(fe_addr_i),
      .id_i(fe_id_i), .wdata_i(fe_wdata_i), .init_done_i(init_done),
      .pop_i(pop), .stall_o(fe_stall_o),
      .head_valid_o(head_valid), .head_write_o(head_write), .head_addr_o(head_addr),
      .head_id_o(head_id), .head_wdata_o(head_wdata)
   );

   refresh_timer #(.AREFI_CYCLES(AREFI_CYCLES)) u_refresh (
      .clk(clk), .rst_n_i(rst_n_i), .init_done_i(init_done),
      .ref_ack_i(ref_ack), .ref_req_o(ref_req)
   );

   init_sequencer #(
      .RESET_LOW_CYCLES(RESET_LOW_CYCLES),
      .RESET_HIGH_CYCLES(RESET_HIGH_CYCLES)
   ) u_init (
      .clk(clk), .rst_n_i(rst_n_i), .reset_m_n_o(reset_m_n_o),
      .init_cmd_valid_o(init_cmd_valid), .init_addr_o(init_addr), .init_done_o(init_done)
   );

   cmd_scheduler #(.T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_RFC(T_RFC)) u_sched (
      .clk(clk), .rst_n_i(rst_n_i),
      .head_valid_i(head_valid), .head_write_i(head_write), .head_addr_i(head_addr),
      .head_id_i(head_id), .head_wdata_i(head_wdata),
      .init_cmd_valid_i(init_cmd_valid), .init_addr_i(init_addr), .init_done_i(init_done),
      .ref_req_i(ref_req), .pop_o(pop), .ref_ack_o(ref_ack),
      .cmd_valid_o(ctrl_valid_o), .cmd_o(ctrl_cmd_o), .bank_o(ctrl_bank_o),
      .addr_o(ctrl_addr_o), .id_o(ctrl_id_o), .w_data_o(ctrl_w_data_o)
   );

   read_return u_rret (
      .clk(clk), .rst_n_i(rst_n_i),
      .r_data_i(ctrl_r_data_i), .r_id_i(ctrl_r_id_i), .r_valid_i(ctrl_r_valid_i),
      .fe_grant_i(fe_rgrant_i), .r_grant_o(ctrl_r_grant_o),
      .fe_rdata_o(fe_rdata_o), .fe_rid_o(fe_rid_o), .fe_rvalid_o(fe_rvalid_o)
   );

endmodule

`default_nettype wire

//--- verification/mem_ctrl_tb.sv
/*
 * Memory controller testbench: random front-end traffic, DRAM responder
 * model with command legality checks, and an in-order read scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_tb;

   localparam int RESET_LOW   = 20;
   localparam int RESET_HIGH  = 10;
   localparam int AREFI       = 300;
   localparam int T_RCD       = 3;
   localparam int T_RP        = 3;
   localparam int T_RAS       = 6;
   localparam int T_RFC       = 10;
   localparam int RD_LATENCY  = 6;     // Responder RD to data, in cycles
   localparam int REF_SLACK   = 40;
   localparam int REQ_LIMIT   = 200;
   localparam int DRAIN_LIMIT = 2000;
   localparam int NB          = mc_pkg::DRAM_BANKS;

   logic clk, rst_n_i;
   logic fe_req_i, fe_write_i, fe_stall_o, fe_rvalid_o, fe_rgrant_i;
   logic ctrl_valid_o, ctrl_r_valid_i, ctrl_r_grant_o, reset_m_n_o;
   mc_pkg::addr_t      fe_addr_i;
   mc_pkg::id_t        fe_id_i, fe_rid_o, ctrl_id_o, ctrl_r_id_i;
   mc_pkg::data_t      fe_wdata_i, fe_rdata_o, ctrl_w_data_o, ctrl_r_data_i;
   mc_pkg::dram_cmd_t  ctrl_cmd_o;
   mc_pkg::bank_t      ctrl_bank_o;
   mc_pkg::dram_addr_t ctrl_addr_o;

   mem_ctrl_top #(
      .QUEUE_DEPTH(4), .AREFI_CYCLES(AREFI), .T_RCD(T_RCD), .T_RP(T_RP),
      .T_RAS(T_RAS), .T_RFC(T_RFC),
      .RESET_LOW_CYCLES(RESET_LOW), .RESET_HIGH_CYCLES(RESET_HIGH)
   ) dut0 (.*);

   // ****************************************
   // Model state
   // ****************************************
   int   errors, checks, cyc, seed;
   int   last_ref, ref_count, mrs_count, low_cnt;
   logic aborted, rm_seen, stall_seen, r_taken, hold_pending;
   mc_pkg::id_t   next_id, held_id;
   mc_pkg::data_t held_data;
   logic [NB-1:0] bank_open;
   mc_pkg::row_t  open_row [NB];
   int            act_cyc  [NB];
   int            pre_cyc  [NB];
   mc_pkg::data_t dram_mem [mc_pkg::addr_t];   // Responder contents
   mc_pkg::data_t image    [mc_pkg::addr_t];   // Front-end view, in request order
   logic          pend_write [$];              // Accepted, waiting for their CAS
   mc_pkg::addr_t pend_addr  [$];
   mc_pkg::id_t   pend_id    [$];
   mc_pkg::data_t pend_data  [$];
   mc_pkg::id_t   exp_id     [$];              // Scoreboard
   mc_pkg::data_t exp_data   [$];
   int            resp_due   [$];              // Responder read returns
   mc_pkg::data_t resp_data  [$];
   mc_pkg::id_t   resp_id    [$];

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic mc_pkg::data_t fill_pattern(input mc_pkg::addr_t a);
      return {a, 10'h2a5, a ^ 27'h5c3_a5f1};
   endfunction

   function automatic int rand_below(input int n);
      return int'({$random(seed)} % n);
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic flag_error(input string msg);
      errors++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   // ****************************************
   // DRAM responder and command checks
   // ****************************************
   task automatic check_cas(input mc_pkg::bank_t b);
      mc_pkg::addr_t a, key;
      mc_pkg::id_t   id;
      mc_pkg::data_t d;
      check_value("bank open at CAS", 64'(bank_open[b]), 64'd1);
      if (cyc - act_cyc[b] < T_RCD) flag_error($sformatf("tRCD violated on bank %0d", b));
      if (pend_addr.size() == 0) begin
         flag_error("CAS command with no accepted request");
      end else begin
         a  = pend_addr.pop_front();
         id = pend_id.pop_front();
         d  = pend_data.pop_front();
         check_value("CAS is WR", 64'(ctrl_cmd_o == mc_pkg::CMD_WR),
                     64'(pend_write.pop_front()));
         check_value("ctrl_bank_o", 64'(b), 64'(a[mc_pkg::ADDR_W-1 -: mc_pkg::BANK_W]));
         check_value("open row at CAS", 64'(open_row[b]),
                     64'(a[mc_pkg::COL_W +: mc_pkg::ROW_W]));
         check_value("ctrl_addr_o column", 64'(ctrl_addr_o), 64'(a[mc_pkg::COL_W-1:0]));
         check_value("ctrl_id_o", 64'(ctrl_id_o), 64'(id));
         key = {b, open_row[b], ctrl_addr_o[mc_pkg::COL_W-1:0]};
         if (ctrl_cmd_o == mc_pkg::CMD_WR) begin
            check_value("ctrl_w_data_o", ctrl_w_data_o, d);
            dram_mem[key] = ctrl_w_data_o;
         end else begin
            resp_due.push_back(cyc + RD_LATENCY);
            resp_data.push_back(dram_mem.exists(key) ? dram_mem[key] : fill_pattern(key));
            resp_id.push_back(ctrl_id_o);
         end
      end
   endtask

   task automatic check_command();
      mc_pkg::bank_t b;
      b = ctrl_bank_o;
      if (ref_count > 0 && cyc - last_ref < T_RFC)
         flag_error($sformatf("command %0d issued within tRFC of REF", ctrl_cmd_o));
      case (ctrl_cmd_o)
         mc_pkg::CMD_MRS: begin
            if (mrs_count >= 4 || stall_seen) flag_error("MRS outside the power-up sequence");
            else check_value("ctrl_addr_o MRS value", 64'(ctrl_addr_o),
                             64'(mc_pkg::MRS_INIT[mrs_count]));
            mrs_count++;
         end
         mc_pkg::CMD_ACT: begin
            check_value("bank open at ACT", 64'(bank_open[b]), 64'd0);
            if (cyc - pre_cyc[b] < T_RP) flag_error($sformatf("tRP violated on bank %0d", b));
            bank_open[b] = 1'b1;
            open_row[b]  = ctrl_addr_o[mc_pkg::ROW_W-1:0];
            act_cyc[b]   = cyc;
         end
         mc_pkg::CMD_PRE: begin
            check_value("bank open at PRE", 64'(bank_open[b]), 64'd1);
            if (cyc - act_cyc[b] < T_RAS) flag_error($sformatf("tRAS violated on bank %0d", b));
            bank_open[b] = 1'b0;
            pre_cyc[b]   = cyc;
         end
         mc_pkg::CMD_RD, mc_pkg::CMD_WR: check_cas(b);
         mc_pkg::CMD_REF: begin
            check_value("open banks at REF", 64'(bank_open), 64'd0);
            if (ref_count > 0 && cyc - last_ref > AREFI + REF_SLACK)
               flag_error($sformatf("REF interval of %0d cycles too long", cyc - last_ref));
            last_ref = cyc;
            ref_count++;
         end
         default: flag_error($sformatf("unknown command code %0d", ctrl_cmd_o));
      endcase
   endtask

   task automatic check_read_port();
      if (hold_pending) begin                      // Held result must not move
         check_value("fe_rvalid_o while held", 64'(fe_rvalid_o), 64'd1);
         check_value("fe_rdata_o while held", fe_rdata_o, held_data);
         check_value("fe_rid_o while held", 64'(fe_rid_o), 64'(held_id));
      end
      hold_pending = fe_rvalid_o && !fe_rgrant_i;
      held_data    = fe_rdata_o;
      held_id      = fe_rid_o;
      if (fe_rvalid_o && fe_rgrant_i) begin
         if (exp_id.size() == 0) begin
            flag_error("read result with no read outstanding");
         end else begin
            check_value("fe_rid_o", 64'(fe_rid_o), 64'(exp_id.pop_front()));
            check_value("fe_rdata_o", fe_rdata_o, exp_data.pop_front());
         end
      end
   endtask

   // Outputs and handshakes sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n_i) begin
         if (!reset_m_n_o) begin
            low_cnt++;
         end else if (!rm_seen) begin
            rm_seen = 1'b1;
            check_value("reset_m_n_o low cycles", 64'(low_cnt), 64'(RESET_LOW));
         end
         if (ctrl_valid_o) check_command();
         if (!fe_stall_o && !stall_seen) begin
            stall_seen = 1'b1;
            check_value("MRS count at init done", 64'(mrs_count), 64'd4);
         end
         check_read_port();
         r_taken = ctrl_r_valid_i && ctrl_r_grant_o;
         cyc++;
      end
   end

   always @(posedge clk) begin
      #2;
      if (r_taken && resp_due.size() > 0) begin
         void'(resp_due.pop_front());
         void'(resp_data.pop_front());
         void'(resp_id.pop_front());
      end
      r_taken = 1'b0;
      ctrl_r_valid_i = (resp_due.size() > 0) && (cyc >= resp_due[0]);
      if (ctrl_r_valid_i) begin
         ctrl_r_data_i = resp_data[0];
         ctrl_r_id_i   = resp_id[0];
      end
   end

   // ****************************************
   // Front-end stimulus
   // ****************************************
   task automatic step_cycle();
      @(posedge clk);
      #2;
      fe_rgrant_i = (rand_below(10) < 6);    // Random read back-pressure
   endtask

   task automatic record_request();
      pend_write.push_back(fe_write_i);
      pend_addr.push_back(fe_addr_i);
      pend_id.push_back(fe_id_i);
      pend_data.push_back(fe_wdata_i);
      if (fe_write_i) begin
         image[fe_addr_i] = fe_wdata_i;
      end else begin
         exp_id.push_back(fe_id_i);
         exp_data.push_back(image.exists(fe_addr_i) ? image[fe_addr_i] : fill_pattern(fe_addr_i));
      end
   endtask

   task automatic send_request(input logic wr, input int limit);
      int   waited;
      logic accepted;
      // A few banks and rows, so both row hits and misses occur
      fe_addr_i  = {mc_pkg::bank_t'(rand_below(4)),
                    mc_pkg::row_t'(rand_below(3) * 'h0a3 + 'h011),
                    mc_pkg::col_t'(rand_below(8) * 8)};
      fe_wdata_i = {$random(seed), $random(seed)};
      fe_write_i = wr;
      fe_id_i    = next_id;
      accepted   = 1'b0;
      waited     = 0;
      while (!accepted && waited < limit) begin
         fe_req_i = (rand_below(4) != 0);
         @(negedge clk);
         accepted = fe_req_i && !fe_stall_o;
         if (accepted) record_request();
         step_cycle();
         waited++;
      end
      fe_req_i = 1'b0;
      if (accepted) begin
         next_id++;
      end else begin
         flag_error($sformatf("request %0d not accepted within %0d cycles", next_id, limit));
         aborted = 1'b1;
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while ((exp_id.size() != 0 || pend_addr.size() != 0 || resp_due.size() != 0)
             && waited < DRAIN_LIMIT) begin
         step_cycle();
         waited++;
      end
      if (exp_id.size() != 0 || pend_addr.size() != 0 || resp_due.size() != 0) begin
         flag_error("outstanding requests or read results not drained in time");
         aborted = 1'b1;
      end
   endtask

   task automatic wait_refreshes();
      int waited;
      waited = 0;
      while (ref_count < 3 && waited < 4 * AREFI) begin
         step_cycle();
         waited++;
      end
      if (ref_count < 3) flag_error("fewer than three REF commands seen");
   endtask

   initial begin
      seed = 32'ha467_c75a;
      errors = 0;
      checks = 0;
      cyc = 0;
      rst_n_i = 1'b0;
      fe_req_i = 1'b0;
      fe_write_i = 1'b0;
      fe_addr_i = '0;
      fe_id_i = '0;
      fe_wdata_i = '0;
      fe_rgrant_i = 1'b0;
      ctrl_r_data_i = '0;
      ctrl_r_id_i = '0;
      ctrl_r_valid_i = 1'b0;
      {aborted, rm_seen, stall_seen, r_taken, hold_pending} = '0;
      {last_ref, ref_count, mrs_count, low_cnt} = '0;
      next_id = '0;
      bank_open = '0;
      for (int b = 0; b < NB; b++) begin
         act_cyc[b]  = -1000;
         pre_cyc[b]  = -1000;
         open_row[b] = '0;
      end

      repeat (9) @(posedge clk);
      @(negedge clk);
      check_value("fe_stall_o in reset", 64'(fe_stall_o), 64'd1);
      check_value("ctrl_valid_o in reset", 64'(ctrl_valid_o), 64'd0);
      check_value("reset_m_n_o in reset", 64'(reset_m_n_o), 64'd0);
      check_value("fe_rvalid_o in reset", 64'(fe_rvalid_o), 64'd0);
      check_value("ctrl_r_grant_o in reset", 64'(ctrl_r_grant_o), 64'd0);
      @(posedge clk);
      #2;
      rst_n_i = 1'b1;

      // First request spans the whole power-up stall
      send_request(1'b1, RESET_LOW + RESET_HIGH + 50);
      for (int i = 0; i < 150 && !aborted; i++) send_request(rand_below(100) < 70, REQ_LIMIT);
      for (int i = 0; i < 250 && !aborted; i++) send_request(rand_below(100) < 25, REQ_LIMIT);
      if (!aborted) wait_drained();
      if (!aborted) wait_refreshes();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
logic/mc_pkg.sv
logic/request_queue.sv
logic/refresh_timer.sv
logic/init_sequencer.sv
logic/cmd_scheduler.sv
logic/read_return.sv
logic/mem_ctrl_top.sv
verification/mem_ctrl_tb.sv

//--- Makefile
# Verilator lint and simulation of the memory controller request path

TOP := mem_ctrl_tb
BIN := obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module $(TOP)

$(BIN): sim.f $(wildcard logic/*.sv verification/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

# Fails on a non-zero exit or when the log holds the fail message
sim: $(BIN)
	./$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failures found" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
